// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps -Wall
TOP       ?= SPIBlockTb
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
RUNARGS   ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

# Pass only when the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJDIR)/V$(TOP) $(RUNARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== SPIBlock.sv ====
//---------------------------------------------------------------------
// SPI management block, slave on the USI register bus
// Mode 0 single-byte transfers to one of three devices
// MOSI output only, MISO input only, wp and hold set by software
//---------------------------------------------------------------------
`timescale 1ns/1ps

module SPIBlock
	import UsiBusPkg::*, SpiPkg::*;
(
	// Bus slave
	input  usiData_t sUsiWd,
	input  usiAdrs_t sUsiAdrs,
	input            sUsiWCke,
	output usiData_t sUsiRd,
	output logic     sUsiVd,
	// SPI pins
	output logic     spiSck,
	output logic     spiMosi,
	input            spiMiso,
	output logic     spiWp,			// Active low write protect
	output logic     spiHold,		// Active low hold
	output logic     spiConfigCs,
	output logic     spiCs1,
	output logic     spiCs2,
	// Clock and reset
	input            sysClk,
	input            arstN
);

	//-----------------------------------------------------------------
	// Internal nets
	//-----------------------------------------------------------------
	logic     start;
	spiByte_t txByte;
	csSel_t   csSel;
	spiDiv_t  div;
	logic     busy;
	spiByte_t rxByte;
	logic     run;
	logic     riseStb;
	logic     fallStb;

	// Registers and bus read-back
	SPICsr csr0 (
		.sUsiWd   (sUsiWd),
		.sUsiAdrs (sUsiAdrs),
		.sUsiWCke (sUsiWCke),
		.sUsiRd   (sUsiRd),
		.sUsiVd   (sUsiVd),
		.busy     (busy),
		.rxByte   (rxByte),
		.start    (start),
		.txByte   (txByte),
		.csSel    (csSel),
		.div      (div),
		.spiWp    (spiWp),
		.spiHold  (spiHold),
		.sysClk   (sysClk),
		.arstN    (arstN)
	);

	// sck and its edge strobes
	SPIClkGen clkGen0 (
		.run     (run),
		.div     (div),
		.spiSck  (spiSck),
		.riseStb (riseStb),
		.fallStb (fallStb),
		.sysClk  (sysClk),
		.arstN   (arstN)
	);

	// Shift engine and chip selects
	SPIShifter shifter0 (
		.start       (start),
		.txByte      (txByte),
		.csSel       (csSel),
		.busy        (busy),
		.rxByte      (rxByte),
		.riseStb     (riseStb),
		.fallStb     (fallStb),
		.run         (run),
		.spiMiso     (spiMiso),
		.spiMosi     (spiMosi),
		.spiConfigCs (spiConfigCs),
		.spiCs1      (spiCs1),
		.spiCs2      (spiCs2),
		.sysClk      (sysClk),
		.arstN       (arstN)
	);

endmodule

// ==== SPIBlockTb.sv ====
//----------------------------------------------------------------------
// Testbench for the SPI management block
// Inputs change 10 ns after each rising sysClk edge, outputs read there too
// Value checks here, pin and bus protocol in the bound checker
//----------------------------------------------------------------------
`timescale 1ns/1ps

module SPIBlockTb
	import UsiBusPkg::*, SpiPkg::*;
();

	localparam int       cXferMax   = 16 * 4;		// Longest transfer, div 3
	localparam int       cBusBudget = 2720;			// Bus access, polling and margin
	localparam int       cTimeout   = 20 * cXferMax + cBusBudget;
	localparam usiData_t cCtrlIdle  = 32'h18;		// Disabled, wpN and holdN high

	logic     sysClk;
	logic     arstN;
	usiData_t sUsiWd;
	usiAdrs_t sUsiAdrs;
	logic     sUsiWCke;
	usiData_t sUsiRd;
	logic     sUsiVd;
	logic     spiSck;
	logic     spiMosi;
	logic     spiMiso;
	logic     spiWp;
	logic     spiHold;
	logic     spiConfigCs;
	logic     spiCs1;
	logic     spiCs2;

	int         testErrs;
	int         testPass;
	int         testFail;
	int         cycleCnt;
	logic [7:0] lfsr = 8'd34;	// Seed

	// Device model state
	spiByte_t   devReply;		// Shifted out on MISO
	spiByte_t   devShift;
	spiByte_t   devRx;			// Collected from MOSI
	logic       loopback;		// MISO copies MOSI
	logic       csPrev;
	logic       csNow;
	logic       sckPrev;
	logic [2:0] csSeenLow;		// {cs2, cs1, config} seen low in a transfer

	SPIBlock dut0 (.*);

	initial
	begin
		sysClk = 1'b0;
		forever #50 sysClk = ~sysClk;
	end

	initial
	begin
		cycleCnt = 0;
		while (cycleCnt < cTimeout)
		begin
			@(posedge sysClk);
			cycleCnt++;
		end
		$display("Timeout after %0d cycles, a test did not finish", cTimeout);
		$display(">>> FAIL");
		$finish;
	end

	// --------------------------------------------------------------------
	// Helpers
	// --------------------------------------------------------------------
	// Fibonacci LFSR, taps 8 6 5 4
	function automatic logic [7:0] lfsrStep(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	function automatic logic [15:0] randBits(input int nBits);
		logic [15:0] val;
		val = '0;
		for (int i = 0; i < nBits; i++)
		begin
			lfsr = lfsrStep(lfsr);		// One step per bit
			val  = {val[14:0], lfsr[0]};
		end
		return val;
	endfunction

	function automatic usiAdrs_t regAdrs(input logic [1:0] ofs);
		return {cSpiBlockBase, 20'd0, ofs, 2'd0};
	endfunction

	task automatic tick();
		@(posedge sysClk);
		#10;
	endtask

	task automatic busWrite(input logic [1:0] ofs, input usiData_t data);
		sUsiAdrs = regAdrs(ofs);
		sUsiWd   = data;
		sUsiWCke = 1'b1;
		tick();					// Register updates at this edge
		sUsiWCke = 1'b0;
		sUsiAdrs = '0;			// Park outside the block
	endtask

	task automatic busRead(input usiAdrs_t adrs, output usiData_t data, output logic vd);
		sUsiAdrs = adrs;
		tick();
		data     = sUsiRd;		// Registered the edge after the hit
		vd       = sUsiVd;
		sUsiAdrs = '0;
	endtask

	task automatic checkEq(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		assert (actVal === expVal)
		else
		begin
			$display("Mismatch %s expected %h actual %h", name, expVal, actVal);
			testErrs++;
		end
	endtask

	task automatic finishTest(input string name);
		if (testErrs == 0)
		begin
			testPass++;
			$display("Test %s passed", name);
		end
		else
		begin
			testFail++;
			$display("Test %s failed with %0d errors", name, testErrs);
		end
		testErrs = 0;
	endtask

	// One transfer, busy length counted in STAT reads, one read per cycle
	task automatic runXfer(input csSel_t cs, input spiDiv_t dv, input spiByte_t tx,
		input logic dropTx, output int busyCnt, output spiByte_t rx);
		usiData_t d;
		logic     vd;
		busWrite(cRegCtrl, {27'd0, 2'b11, cs, 1'b1});
		busWrite(cRegDiv, {16'd0, dv});
		csSeenLow = '0;
		busWrite(cRegTx, {24'd0, tx});
		busyCnt = 0;
		if (dropTx)
		begin
			busWrite(cRegTx, {24'd0, ~tx});		// Lands while busy
			busyCnt = 1;
		end
		do
		begin
			busRead(regAdrs(cRegStat), d, vd);
			csSeenLow |= ~{spiCs2, spiCs1, spiConfigCs};
			if (d[8])
				busyCnt++;
		end
		while (d[8] && busyCnt <= cXferMax);
		assert (!d[8])
		else
		begin
			$display("Busy did not clear within the longest transfer time");
			testErrs++;
		end
		rx = d[7:0];
	endtask

	// --------------------------------------------------------------------
	// Device model, next MISO bit after each sck fall
	// --------------------------------------------------------------------
	initial
	begin
		spiMiso  = 1'b0;
		loopback = 1'b0;
		devReply = '0;
		devShift = '0;
		devRx    = '0;
		csPrev   = 1'b1;
		sckPrev  = 1'b0;
		forever
		begin
			tick();
			csNow = spiConfigCs & spiCs1 & spiCs2;
			if (csPrev && !csNow)
				devShift = devReply;					// MSB out as select falls
			else if (!csNow && sckPrev && !spiSck)
				devShift = {devShift[6:0], 1'b0};
			if (!csNow && !sckPrev && spiSck)
				devRx = {devRx[6:0], spiMosi};			// Rising edge capture
			spiMiso = loopback ? spiMosi : devShift[7];
			csPrev  = csNow;
			sckPrev = spiSck;
		end
	end

	// --------------------------------------------------------------------
	// Tests
	// --------------------------------------------------------------------
	initial
	begin
		usiData_t d;
		usiData_t v;
		logic     vd;
		int       cnt;
		spiByte_t rx;
		spiByte_t tx;
		spiDiv_t  dv;
		testErrs = 0;
		testPass = 0;
		testFail = 0;
		sUsiWd   = '0;
		sUsiAdrs = '0;
		sUsiWCke = 1'b0;
		arstN    = 1'b0;
		repeat (8) @(posedge sysClk);
		#10;
		arstN = 1'b1;

		// Reset values, read-back under field masks, miss
		busRead(regAdrs(cRegStat), d, vd);
		checkEq("resetStat", 32'h0, d);
		busRead(regAdrs(cRegCtrl), d, vd);
		checkEq("resetCtrl", cCtrlIdle, d);
		v = {16'd0, randBits(16)};
		busWrite(cRegTx, v);					// Still disabled
		busRead(regAdrs(cRegTx), d, vd);
		checkEq("txReadback", v & 32'hFF, d);
		v = {16'd0, randBits(16)};
		busWrite(cRegDiv, v);
		busRead(regAdrs(cRegDiv), d, vd);
		checkEq("divReadback", v & 32'hFFFF, d);
		v = {16'd0, randBits(16)} & 32'hFFFE;	// Enable kept off
		busWrite(cRegCtrl, v);
		busRead(regAdrs(cRegCtrl), d, vd);
		checkEq("ctrlReadback", v & 32'h1F, d);
		busWrite(cRegCtrl, cCtrlIdle);
		busRead({8'h04, 24'd0}, d, vd);
		checkEq("missValid", 32'h0, vd);
		checkEq("missData", 32'h0, d);
		finishTest("resetReadback");

		// Transfers against the device model
		for (int i = 0; i < 6; i++)
		begin
			dv       = spiDiv_t'(randBits(2));
			tx       = spiByte_t'(randBits(8));
			devReply = spiByte_t'(randBits(8));
			runXfer(cCsConfig, dv, tx, 1'b0, cnt, rx);
			checkEq("xferMosi", tx, devRx);
			checkEq("xferMiso", devReply, rx);
			checkEq("xferBusyLen", 16 * (dv + 1), cnt);
		end
		finishTest("deviceXfer");

		// Chip select routing, then no select in loopback
		for (int c = 1; c < 4; c++)
		begin
			devReply = spiByte_t'(randBits(8));
			runXfer(csSel_t'(c), 16'd0, spiByte_t'(randBits(8)), 1'b0, cnt, rx);
			checkEq("csRoute", 3'b001 << (c - 1), csSeenLow);
			checkEq("csMiso", devReply, rx);
		end
		loopback = 1'b1;
		tx       = spiByte_t'(randBits(8));
		runXfer(cCsNone, 16'd1, tx, 1'b0, cnt, rx);
		checkEq("csNoneLow", 32'h0, csSeenLow);
		checkEq("csNoneLoop", tx, rx);
		loopback = 1'b0;
		finishTest("csRouting");

		// TX writes while busy and while disabled
		tx       = spiByte_t'(randBits(8));
		devReply = spiByte_t'(randBits(8));
		runXfer(cCsDev1, 16'd3, tx, 1'b1, cnt, rx);
		checkEq("dropBusyLen", 16 * 4, cnt);
		checkEq("dropBusyRx", devReply, rx);
		checkEq("dropBusyMosi", tx, devRx);
		busWrite(cRegCtrl, cCtrlIdle);
		busWrite(cRegTx, {24'd0, ~tx});
		busRead(regAdrs(cRegStat), d, vd);
		checkEq("dropIdleStat", {24'd0, devReply}, d);	// Busy low, byte kept
		finishTest("droppedWrites");

		// wpN and holdN straight to the pins
		busWrite(cRegCtrl, 32'h10);
		checkEq("pinWpLow", 32'h0, spiWp);
		checkEq("pinHoldHigh", 32'h1, spiHold);
		busWrite(cRegCtrl, 32'h08);
		checkEq("pinWpHigh", 32'h1, spiWp);
		checkEq("pinHoldLow", 32'h0, spiHold);
		busWrite(cRegCtrl, cCtrlIdle);
		checkEq("pinWpIdle", 32'h1, spiWp);
		checkEq("pinHoldIdle", 32'h1, spiHold);
		finishTest("pinControl");

		$display("Tests passed %0d failed %0d, bound assertion failures %0d",
			testPass, testFail, dut0.chk0.assertFails);
		if (testFail == 0 && dut0.chk0.assertFails == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== SPIBlock_chk.sv ====
//----------------------------------------------------------------------
// Pin and bus protocol checker, bound into every SPIBlock
// Sampled on rising sysClk, quiet while arstN is low
//----------------------------------------------------------------------
`timescale 1ns/1ps

module SPIBlockChk
	import UsiBusPkg::*, SpiPkg::*;
(
	input            sysClk,
	input            arstN,
	input usiAdrs_t  sUsiAdrs,
	input            sUsiWCke,
	input usiData_t  sUsiRd,
	input            sUsiVd,
	input            busy,
	input spiState_t state,		// Shifter FSM
	input            spiSck,
	input            spiConfigCs,
	input            spiCs1,
	input            spiCs2
);

	int         assertFails = 0;	// Failure count, read at end of run
	logic       rdHit;
	logic [2:0] csLow;

	assign rdHit = (sUsiAdrs[cBusAdrsBit-1 -: cBlockAdrsMap] == cSpiBlockBase) && !sUsiWCke;
	assign csLow = ~{spiCs2, spiCs1, spiConfigCs};

	// --------------------------------------------------------------------
	// SPI pins
	// --------------------------------------------------------------------
	csOnlyBusy: assert property (@(posedge sysClk) disable iff (!arstN)
		!busy |-> csLow == 3'b000)
	else
	begin
		$error("Chip select low while the shifter is idle");
		assertFails++;
	end

	csOneHot: assert property (@(posedge sysClk) disable iff (!arstN) $onehot0(csLow))
	else
	begin
		$error("More than one chip select low");
		assertFails++;
	end

	sckParked: assert property (@(posedge sysClk) disable iff (!arstN)
		state == Idle |-> !spiSck)
	else
	begin
		$error("sck high with the shifter idle");
		assertFails++;
	end

	// --------------------------------------------------------------------
	// Bus read side
	// --------------------------------------------------------------------
	vdAfterHit: assert property (@(posedge sysClk) disable iff (!arstN)
		sUsiVd == $past(rdHit))
	else
	begin
		$error("sUsiVd does not follow a read hit by one cycle");
		assertFails++;
	end

	rdZeroIdle: assert property (@(posedge sysClk) disable iff (!arstN)
		!sUsiVd |-> sUsiRd == '0)
	else
	begin
		$error("sUsiRd not zero while sUsiVd is low");
		assertFails++;
	end

endmodule

bind SPIBlock SPIBlockChk chk0 (
	.sysClk      (sysClk),
	.arstN       (arstN),
	.sUsiAdrs    (sUsiAdrs),
	.sUsiWCke    (sUsiWCke),
	.sUsiRd      (sUsiRd),
	.sUsiVd      (sUsiVd),
	.busy        (busy),
	.state       (shifter0.state),
	.spiSck      (spiSck),
	.spiConfigCs (spiConfigCs),
	.spiCs1      (spiCs1),
	.spiCs2      (spiCs2)
);

// ==== SPIClkGen.sv ====
//---------------------------------------------------------------------
// SPI clock divider, sck toggles every div+1 cycles while run is high
// Strobes are combinational and mark the edge at the next clock
// div is sampled while idle and must stay put during a transfer
//---------------------------------------------------------------------
`timescale 1ns/1ps

module SPIClkGen
	import SpiPkg::*;
(
	input           run,			// Transfer in progress
	input  spiDiv_t div,			// Half-period minus one
	output logic    spiSck,			// Mode 0, parks low
	output logic    riseStb,		// sck rises at the next edge
	output logic    fallStb,		// sck falls at the next edge
	input           sysClk,
	input           arstN
);

	spiDiv_t cnt;		// Cycles left in this half period
	logic    expire;

	assign expire = run && (cnt == '0);

	// Down-counter, held at div while idle so the first half is full length
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
			cnt <= '0;
		else if (!run || expire)
			cnt <= div;
		else
			cnt <= cnt - 1'b1;
	end

	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
			spiSck <= 1'b0;
		else if (!run)
			spiSck <= 1'b0;		// Park low between transfers
		else if (expire)
			spiSck <= ~spiSck;
	end

	// Edge direction follows the current level
	assign riseStb = expire & ~spiSck;
	assign fallStb = expire & spiSck;

endmodule

// ==== SPICsr.sv ====
//---------------------------------------------------------------------
// Control and status registers of the SPI block on the USI bus
// Read data comes one cycle after the hit, zero when not valid
// TX write while busy or disabled is dropped without notice
//---------------------------------------------------------------------
`timescale 1ns/1ps

module SPICsr
	import UsiBusPkg::*, SpiPkg::*;
(
	// Bus slave
	input  usiData_t sUsiWd,		// Write data from the master
	input  usiAdrs_t sUsiAdrs,		// Driven every cycle
	input            sUsiWCke,		// One-cycle write strobe
	output usiData_t sUsiRd,		// Read data, zero when sUsiVd low
	output logic     sUsiVd,		// High the cycle after a read hit
	// Shifter side
	input            busy,
	input  spiByte_t rxByte,
	output logic     start,			// One-cycle transfer request
	output spiByte_t txByte,
	output csSel_t   csSel,
	output spiDiv_t  div,
	// Static pins
	output logic     spiWp,
	output logic     spiHold,
	// Clock and reset
	input            sysClk,
	input            arstN
);

	//-----------------------------------------------------------------
	// Address decode
	//-----------------------------------------------------------------
	logic       blkHit;
	logic [1:0] regOfs;
	logic       wrHit;
	logic       rdHit;
	logic       txWr;

	assign blkHit = sUsiAdrs[cBusAdrsBit-1 -: cBlockAdrsMap] == cSpiBlockBase;
	assign regOfs = sUsiAdrs[cRegOfsLsb+1:cRegOfsLsb];
	assign wrHit  = blkHit & sUsiWCke;
	assign rdHit  = blkHit & ~sUsiWCke;		// Any hit without write is a read
	assign txWr   = wrHit && (regOfs == cRegTx);

	//-----------------------------------------------------------------
	// Registers
	//-----------------------------------------------------------------
	logic     ctrlEn;
	csSel_t   ctrlCs;
	logic     ctrlWpN;
	logic     ctrlHoldN;
	spiDiv_t  divReg;
	spiByte_t txReg;

	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			{ctrlHoldN, ctrlWpN, ctrlCs, ctrlEn} <= cCtrlReset;
			divReg <= '0;
		end
		else if (wrHit)
		begin
			case (regOfs)
				cRegCtrl:
				begin
					ctrlEn    <= sUsiWd[0];
					ctrlCs    <= csSel_t'(sUsiWd[2:1]);
					ctrlWpN   <= sUsiWd[3];
					ctrlHoldN <= sUsiWd[4];
				end
				cRegDiv:  divReg <= spiDiv_t'(sUsiWd[cSpiDivBit-1:0]);
				default:  ;		// TX and STAT handled elsewhere, STAT is read only
			endcase
		end
	end

	// Transmit byte kept for read-back only
	always_ff @(posedge sysClk)
	begin
		if (txWr)
			txReg <= spiByte_t'(sUsiWd[cSpiByteBit-1:0]);
	end

	// Start straight from the write so busy rises on the next cycle
	assign start  = txWr & ctrlEn & ~busy;
	assign txByte = spiByte_t'(sUsiWd[cSpiByteBit-1:0]);	// Taken by the shifter with start

	assign csSel   = ctrlCs;
	assign div     = divReg;
	assign spiWp   = ctrlWpN;
	assign spiHold = ctrlHoldN;

	//-----------------------------------------------------------------
	// Read-back
	//-----------------------------------------------------------------
	usiData_t rdMux;

	always_comb
	begin
		rdMux = '0;
		case (regOfs)
			cRegCtrl: rdMux[4:0]            = {ctrlHoldN, ctrlWpN, ctrlCs, ctrlEn};
			cRegDiv:  rdMux[cSpiDivBit-1:0]  = divReg;
			cRegTx:   rdMux[cSpiByteBit-1:0] = txReg;
			default:  rdMux[cSpiByteBit:0]   = {busy, rxByte};	// STAT
		endcase
	end

	// Zero on a miss so slaves can be OR-ed together
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			sUsiRd <= '0;
			sUsiVd <= 1'b0;
		end
		else
		begin
			sUsiRd <= rdHit ? rdMux : '0;
			sUsiVd <= rdHit;
		end
	end

endmodule

// ==== SPIShifter.sv ====
//---------------------------------------------------------------------
// SPI mode 0 shift engine, one 8-bit transfer MSB first
// MISO is sampled without a synchronizer, device timing assumed slow
// Only the chip select latched at start goes low, and only while busy
//---------------------------------------------------------------------
`timescale 1ns/1ps

module SPIShifter
	import SpiPkg::*;
(
	// Request from the CSR
	input            start,			// One-cycle pulse, ignored while busy
	input  spiByte_t txByte,
	input  csSel_t   csSel,
	output logic     busy,
	output spiByte_t rxByte,		// Updated as busy falls
	// Clock generator
	input            riseStb,
	input            fallStb,
	output logic     run,
	// Pins
	input            spiMiso,
	output logic     spiMosi,
	output logic     spiConfigCs,	// Active low
	output logic     spiCs1,		// Active low
	output logic     spiCs2,		// Active low
	input            sysClk,
	input            arstN
);

	spiState_t  state;
	logic [2:0] bitCnt;		// Bit in flight, 0 is the MSB
	spiByte_t   txShift;	// MSB drives MOSI
	spiByte_t   rxShift;
	csSel_t     csLat;

	//-----------------------------------------------------------------
	// State machine
	//-----------------------------------------------------------------
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			state   <= Idle;
			bitCnt  <= '0;
			txShift <= '0;
			rxByte  <= '0;
		end
		else
		begin
			case (state)
				Idle:
				begin
					if (start)
					begin
						state   <= Lead;
						bitCnt  <= '0;
						txShift <= txByte;		// Bit 7 on MOSI with busy
					end
				end
				Lead:
				begin
					if (riseStb)
						state <= Trail;
				end
				Trail:
				begin
					if (fallStb)
					begin
						if (bitCnt == cBitLast)
						begin
							state  <= Idle;
							rxByte <= rxShift;	// Last bit already in
						end
						else
						begin
							state   <= Lead;
							bitCnt  <= bitCnt + 1'b1;
							txShift <= {txShift[cSpiByteBit-2:0], 1'b0};
						end
					end
				end
				default: state <= Idle;
			endcase
		end
	end

	// Receive shift and chip select latch, payload only
	always_ff @(posedge sysClk)
	begin
		if (state == Lead && riseStb)
			rxShift <= {rxShift[cSpiByteBit-2:0], spiMiso};	// Sample on rise
		if (state == Idle && start)
			csLat <= csSel;
	end

	assign busy    = state != Idle;
	assign run     = busy;
	assign spiMosi = txShift[cSpiByteBit-1];

	//-----------------------------------------------------------------
	// Chip selects
	//-----------------------------------------------------------------
	assign spiConfigCs = ~(busy && csLat == cCsConfig);
	assign spiCs1      = ~(busy && csLat == cCsDev1);
	assign spiCs2      = ~(busy && csLat == cCsDev2);	// cCsNone leaves all high

endmodule

// ==== SpiPkg.sv ====
//---------------------------------------------------------------------
// SPI side types for the management block
// Mode 0 only, 8-bit transfers, MSB first
// Divider counts half periods of sck in sysClk cycles minus one
//---------------------------------------------------------------------
package SpiPkg;

	localparam int cSpiByteBit = 8;
	localparam int cSpiDivBit  = 16;
	localparam int cCsSelBit   = 2;

	typedef logic [cSpiByteBit-1:0] spiByte_t;	// One transfer byte
	typedef logic [cSpiDivBit-1:0]  spiDiv_t;	// Half-period divider
	typedef logic [cCsSelBit-1:0]   csSel_t;	// Chip select code

	// Chip select codes
	localparam csSel_t cCsNone   = 2'd0;	// Transfer with no device selected
	localparam csSel_t cCsConfig = 2'd1;	// Configuration flash
	localparam csSel_t cCsDev1   = 2'd2;
	localparam csSel_t cCsDev2   = 2'd3;

	// Index of the last bit in a transfer
	localparam logic [2:0] cBitLast = 3'd7;

	// Shifter states, Lead is sck low and Trail is sck high
	typedef enum logic [1:0]
	{
		Idle,
		Lead,
		Trail
	} spiState_t;

endpackage

// ==== UsiBusPkg.sv ====
//---------------------------------------------------------------------
// USI bus widths, block address map and register offsets
// Single-beat bus, word addressed registers on address bits 3:2
// Upper cBlockAdrsMap address bits select the block
//---------------------------------------------------------------------
package UsiBusPkg;

	// Bus widths
	localparam int cBusDataBit   = 32;		// Read and write data word
	localparam int cBusAdrsBit   = 32;		// Byte address

	typedef logic [cBusDataBit-1:0] usiData_t;
	typedef logic [cBusAdrsBit-1:0] usiAdrs_t;

	//-----------------------------------------------------------------
	// Block address map
	//-----------------------------------------------------------------
	localparam int                      cBlockAdrsMap = 8;		// Upper bits that pick a block
	localparam logic [cBlockAdrsMap-1:0] cSpiBlockBase = 8'h03;	// SPI management block

	// Register word offsets, address bits 3:2
	localparam int         cRegOfsLsb = 2;
	localparam logic [1:0] cRegCtrl   = 2'd0;	// Enable, csSel, wpN, holdN
	localparam logic [1:0] cRegDiv    = 2'd1;	// Half-period divider
	localparam logic [1:0] cRegTx     = 2'd2;	// Write starts a transfer
	localparam logic [1:0] cRegStat   = 2'd3;	// Busy and last received byte

	// CTRL reset value, disabled with wpN and holdN released
	localparam logic [4:0] cCtrlReset = 5'h18;

endpackage

// ==== vlog.f ====
UsiBusPkg.sv
SpiPkg.sv
SPICsr.sv
SPIClkGen.sv
SPIShifter.sv
SPIBlock.sv
SPIBlock_chk.sv
SPIBlockTb.sv
